/* logic/huffman_code_pkg.sv */
package huffman_code_pkg;

   // ****************************************
   // Symbol and code widths
   // ****************************************
   localparam int symbol_width = 8;   // Bits per input symbol.
   localparam int code_max_len = 10;  // Longest code in the table.
   localparam int len_width    = 4;   // Enough for a length of up to 15.

   // ****************************************
   // Canonical table classes
   // ****************************************
   localparam int short_len = 5;      // Symbols 0 to 15.
   localparam int mid_len   = 7;      // Symbols 16 to 47.
   localparam int long_len  = 10;     // Symbols 48 to 255.

   localparam int mid_first  = 16;    // First symbol with a 7-bit code.
   localparam int long_first = 48;    // First symbol with a 10-bit code.

   localparam int mid_base  = 64;     // Code of symbol 16, binary 1000000.
   localparam int long_base = 768;    // Code of symbol 48, binary 1100000000.

   typedef logic [symbol_width-1:0] symbol_t;
   typedef logic [code_max_len-1:0] code_t;     // Right aligned, unused bits zero.
   typedef logic [len_width-1:0]    code_len_t;

endpackage

/* logic/huffman_stream_pkg.sv */
package huffman_stream_pkg;

   // ****************************************
   // Output word and bit buffer
   // ****************************************
   localparam int word_width = 16;    // One output word.

   // The buffer takes a code only below a full word, so it never holds
   // more than word_width - 1 plus the longest code.
   localparam int buf_width = 26;

   localparam int fill_width = 5;     // Counts up to 25 valid bits.

   typedef logic [word_width-1:0] word_t;
   typedef logic [fill_width-1:0] fill_t;

endpackage

/* logic/stream_slice.sv */
`timescale 1ns/10ps

module stream_slice #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     rst,

   input  logic     in_valid,
   input  payload_t in_data,
   output logic     in_ready,

   output logic     out_valid,
   output payload_t out_data,
   input  logic     out_ready
);

   logic take;

   // The slice can load when it is empty or when its item leaves now.
   assign in_ready = !out_valid || out_ready;
   assign take     = in_valid && in_ready;

   // ****************************************
   // Valid flag
   // ****************************************
   always_ff @(posedge clk) begin
      if (rst) begin
         out_valid <= 1'b0;
      end else if (in_ready) begin
         out_valid <= in_valid;  // Empty unless a new item arrives.
      end
   end

   // ****************************************
   // Payload register
   // ****************************************
   always_ff @(posedge clk) begin
      if (take) begin
         out_data <= in_data;    // Held while the consumer stalls.
      end
   end

endmodule

/* logic/code_lookup.sv */
`timescale 1ns/10ps

module code_lookup (
   input  logic                          clk,
   input  logic                          rst,

   input  logic                          sym_valid,
   input  huffman_code_pkg::symbol_t     sym,
   output logic                          sym_ready,

   output logic                          code_valid,
   output huffman_code_pkg::code_t       code,
   output huffman_code_pkg::code_len_t   code_len,
   input  logic                          code_ready
);

   huffman_code_pkg::code_t     next_code;
   huffman_code_pkg::code_len_t next_len;

   // ****************************************
   // Static code tree, given by class rule
   // ****************************************
   always_comb begin
      if (sym < huffman_code_pkg::mid_first) begin
         next_code = huffman_code_pkg::code_t'(sym);  // Code equals the symbol.
         next_len  = huffman_code_pkg::code_len_t'(huffman_code_pkg::short_len);
      end else if (sym < huffman_code_pkg::long_first) begin
         next_code = huffman_code_pkg::code_t'(huffman_code_pkg::mid_base
                        + (sym - huffman_code_pkg::mid_first));
         next_len  = huffman_code_pkg::code_len_t'(huffman_code_pkg::mid_len);
      end else begin
         next_code = huffman_code_pkg::code_t'(huffman_code_pkg::long_base
                        + (sym - huffman_code_pkg::long_first));
         next_len  = huffman_code_pkg::code_len_t'(huffman_code_pkg::long_len);
      end
   end

   // A new symbol is taken whenever the held code is gone or leaving.
   assign sym_ready = !code_valid || code_ready;

   always_ff @(posedge clk) begin
      if (rst) begin
         code_valid <= 1'b0;
      end else if (sym_ready) begin
         code_valid <= sym_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (sym_valid && sym_ready) begin
         code     <= next_code;  // Code and length move together.
         code_len <= next_len;
      end
   end

endmodule

/* logic/bit_packer.sv */
`timescale 1ns/10ps

module bit_packer (
   input  logic                          clk,
   input  logic                          rst,

   input  logic                          code_valid,
   input  huffman_code_pkg::code_t       code,
   input  huffman_code_pkg::code_len_t   code_len,
   output logic                          code_ready,

   output logic                          word_valid,
   output huffman_stream_pkg::word_t     word,
   input  logic                          word_ready
);

   localparam int buf_width  = huffman_stream_pkg::buf_width;
   localparam int word_width = huffman_stream_pkg::word_width;
   localparam int pad_width  = buf_width - huffman_code_pkg::code_max_len;

   // The buffer is MSB aligned. Bits below the fill level carry no data.
   logic [buf_width-1:0]      buf_q;
   huffman_stream_pkg::fill_t fill_q;

   logic                      take_code;
   logic                      take_word;

   logic [buf_width-1:0]      buf_shift;   // Buffer after a word leaves.
   logic [buf_width-1:0]      keep_mask;   // Ones over the bits still valid.
   logic [buf_width-1:0]      code_ext;    // Code widened to the buffer.
   logic [buf_width-1:0]      code_place;  // Code moved just below the fill.
   huffman_stream_pkg::fill_t fill_base;   // Fill after a word leaves.
   huffman_stream_pkg::fill_t fill_next;

   // ****************************************
   // Handshakes
   // ****************************************

   // A full word is on offer once the fill covers the top word_width bits.
   assign word_valid = fill_q >= word_width;
   assign word       = buf_q[buf_width-1 -: word_width];

   // After an outgoing word the fill is always below a word again,
   // so a code can enter in the same cycle.
   assign code_ready = !word_valid || word_ready;

   assign take_code  = code_valid && code_ready;
   assign take_word  = word_valid && word_ready;

   // ****************************************
   // Next buffer contents
   // ****************************************
   always_comb begin
      if (take_word) begin
         buf_shift = buf_q << word_width;  // Remaining bits move to the top.
         fill_base = fill_q - huffman_stream_pkg::fill_t'(word_width);
      end else begin
         buf_shift = buf_q;
         fill_base = fill_q;
      end

      keep_mask  = ~({buf_width{1'b1}} >> fill_base);
      code_ext   = {{pad_width{1'b0}}, code};

      // The last code bit lands at bit buf_width - fill_base - code_len.
      code_place = code_ext << (buf_width - fill_base - code_len);
   end

   always_comb begin
      if (take_code) begin
         fill_next = fill_base + huffman_stream_pkg::fill_t'(code_len);
      end else begin
         fill_next = fill_base;
      end
   end

   // ****************************************
   // Registers
   // ****************************************
   always_ff @(posedge clk) begin
      if (rst) begin
         fill_q <= '0;          // Empty buffer.
      end else begin
         fill_q <= fill_next;
      end
   end

   always_ff @(posedge clk) begin
      if (take_code) begin
         buf_q <= (buf_shift & keep_mask) | code_place;
      end else if (take_word) begin
         buf_q <= buf_shift;
      end
   end

endmodule

/* logic/huffman_encoder.sv */
`timescale 1ns/10ps

module huffman_encoder (
   input  logic                        clk,
   input  logic                        rst,

   input  logic                        sym_valid,
   input  huffman_code_pkg::symbol_t   sym,
   output logic                        sym_ready,

   output logic                        out_valid,
   output huffman_stream_pkg::word_t   out_word,
   input  logic                        out_ready
);

   logic                        q_valid;
   huffman_code_pkg::symbol_t   q_data;
   logic                        q_ready;

   logic                        code_valid;
   huffman_code_pkg::code_t     code;
   huffman_code_pkg::code_len_t code_len;
   logic                        code_ready;

   logic                        word_valid;
   huffman_stream_pkg::word_t   word;
   logic                        word_ready;

   // ****************************************
   // Symbol path
   // ****************************************
   stream_slice #(
      .payload_t (huffman_code_pkg::symbol_t)
   ) u_in_slice (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (sym_valid),
      .in_data   (sym),
      .in_ready  (sym_ready),
      .out_valid (q_valid),
      .out_data  (q_data),
      .out_ready (q_ready)
   );

   code_lookup u_lookup (
      .clk        (clk),
      .rst        (rst),
      .sym_valid  (q_valid),
      .sym        (q_data),
      .sym_ready  (q_ready),
      .code_valid (code_valid),
      .code       (code),
      .code_len   (code_len),
      .code_ready (code_ready)
   );

   // ****************************************
   // Word path
   // ****************************************
   bit_packer u_packer (
      .clk        (clk),
      .rst        (rst),
      .code_valid (code_valid),
      .code       (code),
      .code_len   (code_len),
      .code_ready (code_ready),
      .word_valid (word_valid),
      .word       (word),
      .word_ready (word_ready)
   );

   stream_slice #(
      .payload_t (huffman_stream_pkg::word_t)
   ) u_out_slice (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (word_valid),
      .in_data   (word),
      .in_ready  (word_ready),
      .out_valid (out_valid),
      .out_data  (out_word),
      .out_ready (out_ready)
   );

endmodule

/* sim/huffman_encoder_assert.sv */
`timescale 1ns/10ps

module huffman_encoder_assert (
   input logic                        clk,
   input logic                        rst,
   input logic                        sym_valid,
   input huffman_code_pkg::symbol_t   sym,
   input logic                        sym_ready,
   input logic                        out_valid,
   input huffman_stream_pkg::word_t   out_word,
   input logic                        out_ready
);

   localparam int word_width = huffman_stream_pkg::word_width;

   bit                        ref_bits[$];  // Stream bits not yet sent, oldest first.
   huffman_stream_pkg::word_t exp_word;     // Next 16 bits of the stream.
   logic                      exp_avail;    // A whole word is waiting in the queue.
   int                        fail_count = 0;

   // ****************************************
   // Canonical table by class rule
   // ****************************************
   function automatic int code_length(input int s);
      if (s < 16) begin
         return huffman_code_pkg::short_len;
      end else if (s < 48) begin
         return huffman_code_pkg::mid_len;
      end
      return huffman_code_pkg::long_len;
   endfunction

   function automatic int code_value(input int s);
      if (s < 16) begin
         return s;
      end else if (s < 48) begin
         return 64 + (s - 16);
      end
      return 768 + (s - 48);
   endfunction

   // ****************************************
   // Reference bit queue
   // ****************************************
   always @(posedge clk) begin
      int                        len;
      int                        val;
      huffman_stream_pkg::word_t w;
      if (rst) begin
         ref_bits.delete();
      end else begin
         // A leaving word never holds bits of a symbol entering now.
         if (out_valid && out_ready) begin
            for (int i = 0; i < word_width; i++) begin
               if (ref_bits.size() > 0) begin
                  void'(ref_bits.pop_front());
               end
            end
         end
         if (sym_valid && sym_ready) begin
            len = code_length(sym);
            val = code_value(sym);
            for (int i = len - 1; i >= 0; i--) begin
               ref_bits.push_back(val[i]);  // MSB of the code goes first.
            end
         end
      end
      w = '0;
      for (int i = 0; i < word_width && i < ref_bits.size(); i++) begin
         w[word_width-1-i] = ref_bits[i];
      end
      exp_word  <= w;
      exp_avail <= ref_bits.size() >= word_width;
   end

   // ****************************************
   // Protocol and data checks
   // ****************************************
   a_reset_quiet : assert property (@(posedge clk) rst |=> !out_valid)
      else begin
         fail_count++;
         $error("out_valid was high during reset or in the first cycle after it");
      end

   a_ready_after_reset : assert property (@(posedge clk) $fell(rst) |-> sym_ready)
      else begin
         fail_count++;
         $error("sym_ready was low in the first cycle after reset");
      end

   a_hold_word : assert property (@(posedge clk) disable iff (rst)
         (out_valid && !out_ready) |=> (out_valid && $stable(out_word)))
      else begin
         fail_count++;
         $error("Output word changed or was dropped while out_ready was low");
      end

   a_word_match : assert property (@(posedge clk) disable iff (rst)
         (out_valid && out_ready) |-> (exp_avail && out_word == exp_word))
      else begin
         fail_count++;
         $error("MISMATCH at %0t: word %h, reference %h", $time, out_word, exp_word);
      end

endmodule

bind huffman_encoder huffman_encoder_assert u_checker (
   .clk       (clk),
   .rst       (rst),
   .sym_valid (sym_valid),
   .sym       (sym),
   .sym_ready (sym_ready),
   .out_valid (out_valid),
   .out_word  (out_word),
   .out_ready (out_ready)
);

/* sim/huffman_encoder_tb.sv */
`timescale 1ns/10ps

module huffman_encoder_tb;

   localparam int half_period  = 4;
   localparam int reset_cycles = 16;
   localparam int rand_seed    = 75;
   localparam int wait_limit   = 300;   // Cycles allowed for any single wait.
   localparam int fill_limit   = 50;    // Cycles for sym_ready to fall under a stall.
   localparam int hold_cycles  = 20;
   localparam int mixed_count  = 200;
   localparam int bp_count     = 120;

   logic                      clk;
   logic                      rst;
   logic                      sym_valid;
   huffman_code_pkg::symbol_t sym;
   logic                      sym_ready;
   logic                      out_valid;
   huffman_stream_pkg::word_t out_word;
   logic                      out_ready;

   int out_mode;         // 0 always ready, 1 random, 2 held low.
   int word_count;
   int total_bits;       // Code bits accepted since reset.
   int tb_errors;
   int errors_at_start;
   int tests_run;
   int tests_failed;
   int seed_value;

   huffman_encoder u_huffman_encoder (
      .clk       (clk),
      .rst       (rst),
      .sym_valid (sym_valid),
      .sym       (sym),
      .sym_ready (sym_ready),
      .out_valid (out_valid),
      .out_word  (out_word),
      .out_ready (out_ready)
   );

   always #half_period clk = ~clk;

   // ****************************************
   // Output side
   // ****************************************
   always @(negedge clk) begin
      case (out_mode)
         1: out_ready = ($urandom % 3) != 0;
         2: out_ready = 1'b0;
         default: out_ready = 1'b1;
      endcase
   end

   always @(posedge clk) begin
      if (rst) begin
         word_count <= 0;
      end else if (out_valid && out_ready) begin
         word_count <= word_count + 1;
      end
   end

   // ****************************************
   // Helpers
   // ****************************************
   function automatic int code_bits(input int s);
      if (s < 16) begin
         return 5;
      end else if (s < 48) begin
         return 7;
      end
      return 10;
   endfunction

   // Rotates through the three length classes so each one shows up often.
   function automatic huffman_code_pkg::symbol_t pick_symbol(input int idx);
      case (idx % 3)
         0: return huffman_code_pkg::symbol_t'($urandom % 16);
         1: return huffman_code_pkg::symbol_t'(16 + $urandom % 32);
         default: return huffman_code_pkg::symbol_t'(48 + $urandom % 208);
      endcase
   endfunction

   function automatic int error_total();
      return tb_errors + u_huffman_encoder.u_checker.fail_count;
   endfunction

   // Called on a falling edge, returns on a falling edge.
   task automatic send_symbol(input huffman_code_pkg::symbol_t s);
      int   waited;
      logic accepted;
      waited    = 0;
      accepted  = 1'b0;
      sym_valid = 1'b1;
      sym       = s;
      while (!accepted && waited < wait_limit) begin
         @(posedge clk);
         waited++;
         accepted = sym_ready;
      end
      if (accepted) begin
         total_bits += code_bits(s);
      end else begin
         $display("Timeout: symbol %0d was not accepted within %0d cycles", s, wait_limit);
         tb_errors++;
      end
      @(negedge clk);
      sym_valid = 1'b0;
   endtask

   task automatic drain_and_count();
      int waited;
      int expected;
      expected = total_bits / huffman_stream_pkg::word_width;
      waited   = 0;
      while (word_count < expected && waited < wait_limit) begin
         @(posedge clk);
         waited++;
      end
      if (word_count < expected) begin
         $display("Timeout: output words stopped after %0d cycles", wait_limit);
         tb_errors++;
      end
      waited = 0;
      while (out_valid && waited < wait_limit) begin
         @(posedge clk);
         waited++;
      end
      if (out_valid) begin
         $display("Timeout: out_valid stayed high after the expected words");
         tb_errors++;
      end
      if (word_count != expected) begin
         $display("MISMATCH at %0t: %0d words, expected %0d", $time, word_count, expected);
         tb_errors++;
      end
      @(negedge clk);
   endtask

   task automatic end_test(input string name);
      int errs;
      errs = error_total() - errors_at_start;
      tests_run++;
      if (errs != 0) begin
         tests_failed++;
      end
      $display("test %-14s words %4d  bits %5d  errors %0d", name, word_count, total_bits, errs);
      errors_at_start = error_total();
   endtask

   // Fills the pipeline with the output stalled, then holds the blocked symbol.
   task automatic input_hold();
      int                        waited;
      logic                      stalled;
      huffman_code_pkg::symbol_t s;
      out_mode  <= 2;
      waited    = 0;
      stalled   = 1'b0;
      s         = pick_symbol(2);
      sym_valid = 1'b1;
      sym       = s;
      while (!stalled && waited < fill_limit) begin
         @(posedge clk);
         waited++;
         if (sym_ready) begin
            total_bits += code_bits(s);
            @(negedge clk);
            s   = pick_symbol(waited);
            sym = s;
         end else begin
            stalled = 1'b1;
         end
      end
      if (!stalled) begin
         $display("Timeout: sym_ready did not fall within %0d cycles", fill_limit);
         tb_errors++;
      end
      for (int i = 0; i < hold_cycles && stalled; i++) begin
         @(negedge clk);
         @(posedge clk);
         if (sym_ready && !out_ready) begin
            $display("MISMATCH at %0t: sym_ready rose while the output was held", $time);
            tb_errors++;
         end
      end
      @(negedge clk);
      out_mode <= 0;
      send_symbol(s);  // The blocked symbol is still on the bus.
   endtask

   // ****************************************
   // Test sequence
   // ****************************************
   initial begin
      seed_value      = $urandom(rand_seed);
      clk             = 1'b0;
      rst             = 1'b1;
      sym_valid       = 1'b0;
      sym             = '0;
      out_ready       = 1'b1;
      out_mode        = 0;
      total_bits      = 0;
      tb_errors       = 0;
      errors_at_start = 0;
      tests_run       = 0;
      tests_failed    = 0;

      repeat (reset_cycles) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      @(posedge clk);           // First cycle after reset.
      @(negedge clk);
      end_test("reset");

      for (int i = 0; i < 16; i++) begin
         send_symbol(huffman_code_pkg::symbol_t'(i));
      end
      drain_and_count();
      end_test("short_codes");

      for (int i = 0; i < mixed_count; i++) begin
         send_symbol(pick_symbol(i));
      end
      drain_and_count();
      end_test("mixed_classes");

      out_mode <= 1;
      for (int i = 0; i < bp_count; i++) begin
         send_symbol(pick_symbol(i + 1));
      end
      out_mode <= 0;
      drain_and_count();
      end_test("back_pressure");

      input_hold();
      drain_and_count();
      end_test("input_hold");

      $display("tests %0d, failing tests %0d, failed checks %0d",
               tests_run, tests_failed, error_total());
      if (error_total() == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

/* compile.f */
logic/huffman_code_pkg.sv
logic/huffman_stream_pkg.sv
logic/stream_slice.sv
logic/code_lookup.sv
logic/bit_packer.sv
logic/huffman_encoder.sv
sim/huffman_encoder_assert.sv
sim/huffman_encoder_tb.sv

/* Makefile */
# Verilator build and run for the Huffman encoder testbench.
# Any variable can be overridden, e.g. make LOG=run.log

VERILATOR ?= verilator
TOP       ?= huffman_encoder_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
LINTFLAGS ?= --lint-only --timing --assert

# Assertion errors must not stop the run before the final verdict.
SIM_ARGS  ?= +verilator+error+limit+100000

SIM_BIN    = $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides the result; a crash without a verdict fails too.
run: build
	@$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "Simulation FAILED" $(LOG); then \
		echo "Failure reported in $(LOG)"; exit 1; \
	fi; \
	if [ $$status -ne 0 ]; then \
		echo "Simulator exited with status $$status"; exit 1; \
	fi; \
	if ! grep -q "Simulation PASSED" $(LOG); then \
		echo "No verdict found in $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
